// ==== flist.f ====
tc_pkg.sv
tc_retire_if.sv
tc_fetch.sv
tc_exec.sv
tc_core.sv
tc_core_log.sv
tc_wrapper.sv
tc_wrapper_checker.sv
tb_tc_wrapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tc_wrapper \
  -f flist.f \
  --Mdir obj_dir -o tb_tc_wrapper
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit "$status"
fi

./obj_dir/tb_tc_wrapper
status=$?
if [ "$status" -ne 0 ]; then
  echo "Run ended with status $status"
  exit "$status"
fi

exit 0

// ==== tb_tc_wrapper.sv ====
// Testbench for tc_wrapper with clock, reset, instruction memory model and trace checks
`timescale 1ns/1ps
`default_nettype none

module tb_tc_wrapper import tc_pkg::*; ();

  localparam int COUNT_W     = COUNT_W_DEFAULT;
  localparam int VEC_DEPTH   = 256;
  localparam int MAX_TRACE   = 64;
  localparam int TIMEOUT     = 200;
  localparam int IDLE_CYCLES = 16;

  logic               clk_i = 1'b0;
  logic               rst_i;
  logic               fetch_enable_i;
  logic [XLEN-1:0]    boot_addr_i;
  logic               instr_req_o;
  logic               instr_gnt_i;
  logic               instr_rvalid_i;
  logic [XLEN-1:0]    instr_addr_o;
  logic [XLEN-1:0]    instr_rdata_i;
  logic               trace_valid_o;
  logic [XLEN-1:0]    trace_pc_o;
  logic [XLEN-1:0]    trace_instr_o;
  logic [NREG_W-1:0]  trace_rd_o;
  logic [XLEN-1:0]    trace_wdata_o;
  logic               trace_illegal_o;
  logic [COUNT_W-1:0] retired_count_o;
  logic [COUNT_W-1:0] illegal_count_o;

  // Raw vector words and the tables built from them
  logic [XLEN-1:0]    vec_words [VEC_DEPTH];
  logic [XLEN-1:0]    imem [logic [XLEN-1:0]];
  logic [XLEN-1:0]    exp_pc [MAX_TRACE];
  logic [XLEN-1:0]    exp_instr [MAX_TRACE];
  logic [NREG_W-1:0]  exp_rd [MAX_TRACE];
  logic [XLEN-1:0]    exp_wdata [MAX_TRACE];
  logic               exp_illegal [MAX_TRACE];
  logic [COUNT_W-1:0] exp_retired_final;
  logic [COUNT_W-1:0] exp_illegal_final;
  logic [XLEN-1:0]    boot_addr;
  int                 num_trace;

  tc_wrapper #(
    .COUNT_W ( COUNT_W )
  ) i_tc_wrapper (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .fetch_enable_i  ( fetch_enable_i  ),
    .boot_addr_i     ( boot_addr_i     ),
    .instr_req_o     ( instr_req_o     ),
    .instr_gnt_i     ( instr_gnt_i     ),
    .instr_rvalid_i  ( instr_rvalid_i  ),
    .instr_addr_o    ( instr_addr_o    ),
    .instr_rdata_i   ( instr_rdata_i   ),
    .trace_valid_o   ( trace_valid_o   ),
    .trace_pc_o      ( trace_pc_o      ),
    .trace_instr_o   ( trace_instr_o   ),
    .trace_rd_o      ( trace_rd_o      ),
    .trace_wdata_o   ( trace_wdata_o   ),
    .trace_illegal_o ( trace_illegal_o ),
    .retired_count_o ( retired_count_o ),
    .illegal_count_o ( illegal_count_o )
  );

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR: %s", msg);
    stop_with_failure();
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_reg_index(input string name, input logic [NREG_W-1:0] got,
                                 input logic [NREG_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                             input logic [COUNT_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Compares the trace port against expected entry idx
  task automatic check_trace(input int idx);
    check_word($sformatf("trace_pc_o[%0d]", idx), trace_pc_o, exp_pc[idx]);
    check_word($sformatf("trace_instr_o[%0d]", idx), trace_instr_o, exp_instr[idx]);
    check_reg_index($sformatf("trace_rd_o[%0d]", idx), trace_rd_o, exp_rd[idx]);
    check_word($sformatf("trace_wdata_o[%0d]", idx), trace_wdata_o, exp_wdata[idx]);
    check_flag($sformatf("trace_illegal_o[%0d]", idx), trace_illegal_o, exp_illegal[idx]);
  endtask

  // Unlisted addresses return a word derived from the address
  function automatic logic [XLEN-1:0] read_imem(input logic [XLEN-1:0] addr);
    if (imem.exists(addr)) begin
      return imem[addr];
    end
    return addr ^ 32'hC3A5_5A3C;
  endfunction

  task automatic load_vectors();
    int num_mem;
    int pos;
    int i;
    $readmemh("tc_vectors.txt", vec_words);
    boot_addr = vec_words[0];
    num_mem   = int'(vec_words[1]);
    num_trace = int'(vec_words[2]);
    if (num_mem < 1 || num_trace < 1 || num_trace > MAX_TRACE ||
        3 + 2 * num_mem + 5 * num_trace + 2 > VEC_DEPTH) begin
      report_problem("vector file header is missing or gives impossible line counts");
    end
    pos = 3;
    for (i = 0; i < num_mem; i++) begin
      imem[vec_words[pos]] = vec_words[pos + 1];
      pos += 2;
    end
    for (i = 0; i < num_trace; i++) begin
      exp_pc[i]      = vec_words[pos];
      exp_instr[i]   = vec_words[pos + 1];
      exp_rd[i]      = vec_words[pos + 2][NREG_W-1:0];
      exp_wdata[i]   = vec_words[pos + 3];
      exp_illegal[i] = vec_words[pos + 4][0];
      pos += 5;
    end
    exp_retired_final = COUNT_W'(vec_words[pos]);
    exp_illegal_final = COUNT_W'(vec_words[pos + 1]);
  endtask

  // Memory model serving one transaction per expected retirement
  task automatic serve_requests();
    int              k;
    int              waited;
    int              gnt_delay;
    int              rsp_delay;
    logic [XLEN-1:0] addr;
    for (k = 0; k < num_trace; k++) begin
      waited = 0;
      @(negedge clk_i);
      while (instr_req_o !== 1'b1) begin
        waited++;
        if (waited > TIMEOUT) begin
          report_problem($sformatf("no instruction request arrived for fetch %0d", k));
        end
        @(negedge clk_i);
      end
      addr = instr_addr_o;
      if (k == 0) begin
        check_word("instr_addr_o (first fetch)", addr, boot_addr_i);
      end
      check_word($sformatf("instr_addr_o[%0d]", k), addr, exp_pc[k]);
      gnt_delay = int'($urandom_range(3, 0));
      rsp_delay = int'($urandom_range(3, 1));
      repeat (gnt_delay) @(posedge clk_i);
      @(posedge clk_i);
      instr_gnt_i <= 1'b1;
      @(posedge clk_i);
      instr_gnt_i <= 1'b0;
      // No new request may start once the last fetch is granted
      if (k == num_trace - 1) begin
        fetch_enable_i <= 1'b0;
      end
      repeat (rsp_delay - 1) @(posedge clk_i);
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= read_imem(addr);
      @(posedge clk_i);
      instr_rvalid_i <= 1'b0;
    end
  endtask

  task automatic collect_trace();
    int k;
    int waited;
    int illegal_seen;
    illegal_seen = 0;
    for (k = 0; k < num_trace; k++) begin
      waited = 0;
      @(negedge clk_i);
      while (trace_valid_o !== 1'b1) begin
        waited++;
        if (waited > TIMEOUT) begin
          report_problem($sformatf("trace entry %0d never appeared on the trace port", k));
        end
        @(negedge clk_i);
      end
      check_trace(k);
      if (exp_illegal[k]) begin
        illegal_seen++;
      end
      check_count($sformatf("retired_count_o[%0d]", k), retired_count_o, COUNT_W'(k + 1));
      check_count($sformatf("illegal_count_o[%0d]", k), illegal_count_o,
                  COUNT_W'(illegal_seen));
    end
  endtask

  // Nothing further may be fetched or retired
  task automatic check_quiet();
    int i;
    for (i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge clk_i);
      check_flag("instr_req_o (fetch disabled)", instr_req_o, 1'b0);
      check_flag("trace_valid_o (after last entry)", trace_valid_o, 1'b0);
    end
  endtask

  initial begin
    void'($urandom(32'haa65));
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    load_vectors();
    boot_addr_i    = boot_addr;
    fetch_enable_i = 1'b1;

    // Reset held for 8 cycles
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("instr_req_o (reset)", instr_req_o, 1'b0);
    check_flag("trace_valid_o (reset)", trace_valid_o, 1'b0);
    check_count("retired_count_o (reset)", retired_count_o, '0);
    check_count("illegal_count_o (reset)", illegal_count_o, '0);
    @(posedge clk_i);
    rst_i <= 1'b0;

    fork
      serve_requests();
      collect_trace();
    join

    check_quiet();
    check_count("retired_count_o (final)", retired_count_o, exp_retired_final);
    check_count("retired_count_o (entries)", retired_count_o, COUNT_W'(num_trace));
    check_count("illegal_count_o (final)", illegal_count_o, exp_illegal_final);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tc_core.sv ====
// Core joining the fetch unit and the execute unit
`timescale 1ns/1ps
`default_nettype none

module tc_core import tc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,

  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,

  tc_retire_if.src        retire_o
);

  logic            instr_valid;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] next_pc;

  tc_fetch fetch_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_valid_o  ( instr_valid    ),
    .instr_o        ( instr          ),
    .pc_o           ( pc             ),
    .next_pc_i      ( next_pc        )
  );

  // Execute answers with the next PC in the same cycle
  tc_exec exec_i (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .instr_valid_i ( instr_valid ),
    .instr_i       ( instr       ),
    .pc_i          ( pc          ),
    .next_pc_o     ( next_pc     ),
    .retire_o      ( retire_o    )
  );

endmodule

`default_nettype wire

// ==== tc_core_log.sv ====
// Registered retirement trace with retired and illegal instruction counters
`timescale 1ns/1ps
`default_nettype none

module tc_core_log import tc_pkg::*; #(
  parameter int COUNT_W = COUNT_W_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_i,
  tc_retire_if.dst           retire_i,

  output logic               trace_valid_o,
  output logic [XLEN-1:0]    trace_pc_o,
  output logic [XLEN-1:0]    trace_instr_o,
  output logic [NREG_W-1:0]  trace_rd_o,
  output logic [XLEN-1:0]    trace_wdata_o,
  output logic               trace_illegal_o,
  output logic [COUNT_W-1:0] retired_count_o,
  output logic [COUNT_W-1:0] illegal_count_o
);

  logic [COUNT_W-1:0] retired_q;
  logic [COUNT_W-1:0] illegal_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      trace_valid_o <= 1'b0;
      retired_q     <= '0;
      illegal_q     <= '0;
    end else begin
      trace_valid_o <= retire_i.valid;
      // Counters wrap silently
      if (retire_i.valid) begin
        retired_q <= retired_q + 1'b1;
        if (retire_i.illegal) begin
          illegal_q <= illegal_q + 1'b1;
        end
      end
    end
  end

  // Record held until the next retirement
  always_ff @(posedge clk_i) begin
    if (retire_i.valid) begin
      trace_pc_o      <= retire_i.pc;
      trace_instr_o   <= retire_i.instr;
      trace_rd_o      <= retire_i.rd;
      trace_wdata_o   <= retire_i.we ? retire_i.wdata : '0;
      trace_illegal_o <= retire_i.illegal;
    end
  end

  assign retired_count_o = retired_q;
  assign illegal_count_o = illegal_q;

endmodule

`default_nettype wire

// ==== tc_exec.sv ====
// Decoder, 16-entry register file, ALU and next-PC logic with retirement output
`timescale 1ns/1ps
`default_nettype none

module tc_exec import tc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] next_pc_o,
  tc_retire_if.src        retire_o
);

  logic [XLEN-1:0]   regs [2**NREG_W];

  opcode_e           opcode;
  logic [NREG_W-1:0] rd;
  logic [NREG_W-1:0] rs1;
  logic [NREG_W-1:0] rs2;
  logic [IMM_W-1:0]  imm16;
  logic [XLEN-1:0]   imm_sext;
  logic [XLEN-1:0]   rs1_val;
  logic [XLEN-1:0]   rs2_val;
  logic [XLEN-1:0]   pc_plus4;
  logic [XLEN-1:0]   jump_target;
  logic [XLEN-1:0]   result;
  logic              wr_req;
  logic              illegal;
  logic              rf_we;

  // Field extraction
  assign opcode = opcode_e'(instr_i[OPC_MSB:OPC_LSB]);
  assign rd     = instr_i[RD_MSB:RD_LSB];
  assign rs1    = instr_i[RS1_MSB:RS1_LSB];
  assign rs2    = instr_i[RS2_MSB:RS2_LSB];
  assign imm16  = instr_i[IMM_MSB:IMM_LSB];

  assign imm_sext = {{(XLEN - IMM_W){imm16[IMM_W-1]}}, imm16};

  // r0 always reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  assign pc_plus4    = pc_i + XLEN'(4);
  // Jump offsets count words
  assign jump_target = pc_i + (imm_sext << 2);

  always_comb begin
    result    = '0;
    wr_req    = 1'b0;
    illegal   = 1'b0;
    next_pc_o = pc_plus4;
    case (opcode)
      OP_ADDI: begin
        result = rs1_val + imm_sext;
        wr_req = 1'b1;
      end
      OP_ADD: begin
        result = rs1_val + rs2_val;
        wr_req = 1'b1;
      end
      OP_SUB: begin
        result = rs1_val - rs2_val;
        wr_req = 1'b1;
      end
      OP_XOR: begin
        result = rs1_val ^ rs2_val;
        wr_req = 1'b1;
      end
      OP_LUI: begin
        result = {imm16, {(XLEN - IMM_W){1'b0}}};
        wr_req = 1'b1;
      end
      // Link value is the return address
      OP_JAL: begin
        result    = pc_plus4;
        wr_req    = 1'b1;
        next_pc_o = jump_target;
      end
      OP_BEQ: begin
        if (rs1_val == rs2_val) begin
          next_pc_o = jump_target;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  assign rf_we = instr_valid_i && wr_req && (rd != '0);

  // No write-back while in reset
  always_ff @(posedge clk_i) begin
    if (!rst_i && rf_we) begin
      regs[rd] <= result;
    end
  end

  // Execution takes one cycle so the instruction retires now
  assign retire_o.valid   = instr_valid_i;
  assign retire_o.pc      = pc_i;
  assign retire_o.instr   = instr_i;
  assign retire_o.rd      = rd;
  assign retire_o.wdata   = result;
  assign retire_o.we      = rf_we;
  assign retire_o.illegal = illegal;

endmodule

`default_nettype wire

// ==== tc_fetch.sv ====
// Instruction fetch FSM with request/grant/response-valid bus and PC register
`timescale 1ns/1ps
`default_nettype none

module tc_fetch import tc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,

  // Instruction bus
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,

  // Towards execute
  output logic            instr_valid_o,
  output logic [XLEN-1:0] instr_o,
  output logic [XLEN-1:0] pc_o,
  input  logic [XLEN-1:0] next_pc_i
);

  fetch_state_e    state_q;
  fetch_state_e    state_d;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] instr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_IDLE: begin
        if (fetch_enable_i) begin
          state_d = FS_REQ;
        end
      end
      // Request and address held until granted
      FS_REQ: begin
        if (instr_gnt_i) begin
          state_d = FS_WAIT;
        end
      end
      FS_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = FS_EXEC;
        end
      end
      // Instruction handed to execute for this single cycle
      FS_EXEC: begin
        state_d = fetch_enable_i ? FS_REQ : FS_IDLE;
      end
      default: state_d = FS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FS_IDLE;
      pc_q    <= boot_addr_i;
    end else begin
      state_q <= state_d;
      if (state_q == FS_EXEC) begin
        pc_q <= next_pc_i;
      end
    end
  end

  // Capture the fetched word
  always_ff @(posedge clk_i) begin
    if (state_q == FS_WAIT && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = (state_q == FS_REQ);
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = (state_q == FS_EXEC);
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;

endmodule

`default_nettype wire

// ==== tc_pkg.sv ====
// Data widths, instruction field positions, opcode and fetch state enums
`default_nettype none

package tc_pkg;

  localparam int XLEN            = 32;
  localparam int NREG_W          = 4;
  localparam int COUNT_W_DEFAULT = 16;

  // Instruction field positions
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RD_MSB  = 27;
  localparam int RD_LSB  = 24;
  localparam int RS1_MSB = 23;
  localparam int RS1_LSB = 20;
  localparam int RS2_MSB = 19;
  localparam int RS2_LSB = 16;
  localparam int IMM_W   = 16;
  localparam int IMM_LSB = 0;
  localparam int IMM_MSB = IMM_LSB + IMM_W - 1;

  // Encodings not listed here retire as illegal
  typedef enum logic [3:0] {
    OP_ADDI = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_XOR  = 4'h4,
    OP_LUI  = 4'h5,
    OP_JAL  = 4'h6,
    OP_BEQ  = 4'h7
  } opcode_e;

  typedef enum logic [1:0] {
    FS_IDLE = 2'd0,
    FS_REQ  = 2'd1,
    FS_WAIT = 2'd2,
    FS_EXEC = 2'd3
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== tc_retire_if.sv ====
// Retirement record interface between the core and the log, with src and dst modports
`timescale 1ns/1ps
`default_nettype none

interface tc_retire_if
  import tc_pkg::*;
();

  // One-cycle pulse per retired instruction
  logic              valid;
  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   instr;
  logic [NREG_W-1:0] rd;
  logic [XLEN-1:0]   wdata;
  // High only when the register file is actually written
  logic              we;
  logic              illegal;

  modport src (
    output valid, pc, instr, rd, wdata, we, illegal
  );

  modport dst (
    input valid, pc, instr, rd, wdata, we, illegal
  );

endinterface

`default_nettype wire

// ==== tc_vectors.txt ====
// Header: boot address, memory line count, trace line count
// Memory: address word. Trace: pc instr rd wdata illegal. Last line: retired illegal
00000100 00000012 00000011
// Program image
00000100 11000005
00000104 1200FFFD
00000108 23120000
0000010C 34120000
00000110 45120000
00000114 5600ABCD
00000118 10100007
0000011C 70130002
00000120 70000003
00000124 1A900001
00000128 70000008
0000012C 67000004
00000130 1D000077
0000013C F8000000
00000140 28670000
00000144 6900FFF8
00000148 3C010000
0000014C 00000000
// Expected retirement trace
00000100 11000005 1 00000005 0
00000104 1200FFFD 2 FFFFFFFD 0
00000108 23120000 3 00000002 0
0000010C 34120000 4 00000008 0
00000110 45120000 5 FFFFFFF8 0
00000114 5600ABCD 6 ABCD0000 0
00000118 10100007 0 00000000 0
0000011C 70130002 0 00000000 0
00000120 70000003 0 00000000 0
0000012C 67000004 7 00000130 0
0000013C F8000000 8 00000000 1
00000140 28670000 8 ABCD0130 0
00000144 6900FFF8 9 00000148 0
00000124 1A900001 A 00000149 0
00000128 70000008 0 00000000 0
00000148 3C010000 C FFFFFFFB 0
0000014C 00000000 0 00000000 1
// Final counters
00000011 00000002

// ==== tc_wrapper.sv ====
// Top level with the core, the execution log and the retirement interface
`timescale 1ns/1ps
`default_nettype none

module tc_wrapper import tc_pkg::*; #(
  parameter int COUNT_W = COUNT_W_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_i,

  input  logic               fetch_enable_i,
  input  logic [XLEN-1:0]    boot_addr_i,

  // Instruction memory interface
  output logic               instr_req_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  output logic [XLEN-1:0]    instr_addr_o,
  input  logic [XLEN-1:0]    instr_rdata_i,

  // Retirement trace
  output logic               trace_valid_o,
  output logic [XLEN-1:0]    trace_pc_o,
  output logic [XLEN-1:0]    trace_instr_o,
  output logic [NREG_W-1:0]  trace_rd_o,
  output logic [XLEN-1:0]    trace_wdata_o,
  output logic               trace_illegal_o,

  output logic [COUNT_W-1:0] retired_count_o,
  output logic [COUNT_W-1:0] illegal_count_o
);

  tc_retire_if retire_if ();

  tc_core core_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .retire_o       ( retire_if.src  )
  );

  // Log sits beside the core and watches every retirement
  tc_core_log #(
    .COUNT_W ( COUNT_W )
  ) core_log_i (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .retire_i        ( retire_if.dst   ),
    .trace_valid_o   ( trace_valid_o   ),
    .trace_pc_o      ( trace_pc_o      ),
    .trace_instr_o   ( trace_instr_o   ),
    .trace_rd_o      ( trace_rd_o      ),
    .trace_wdata_o   ( trace_wdata_o   ),
    .trace_illegal_o ( trace_illegal_o ),
    .retired_count_o ( retired_count_o ),
    .illegal_count_o ( illegal_count_o )
  );

endmodule

`default_nettype wire

// ==== tc_wrapper_checker.sv ====
// Bound assertions on the instruction bus and trace port protocol of tc_wrapper
`timescale 1ns/1ps
`default_nettype none

module tc_wrapper_checker import tc_pkg::*; (
  input logic            clk_i,
  input logic            rst_i,
  input logic            fetch_enable_i,
  input logic            instr_req_o,
  input logic            instr_gnt_i,
  input logic [XLEN-1:0] instr_addr_o,
  input logic            trace_valid_o
);

  // Request and address stay put until the grant is seen
  property p_addr_stable;
    @(posedge clk_i) disable iff (rst_i)
      (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o));
  endproperty

  // A new request only starts while fetch is enabled
  property p_req_needs_enable;
    @(posedge clk_i) disable iff (rst_i)
      $rose(instr_req_o) |-> $past(fetch_enable_i);
  endproperty

  // One retirement at most every other cycle
  property p_trace_single_pulse;
    @(posedge clk_i) disable iff (rst_i)
      trace_valid_o |=> !trace_valid_o;
  endproperty

  a_addr_stable: assert property (p_addr_stable)
    else $error("instruction address or request changed before the grant");

  a_req_needs_enable: assert property (p_req_needs_enable)
    else $error("instruction request started without fetch enable");

  a_trace_single_pulse: assert property (p_trace_single_pulse)
    else $error("trace valid high in two consecutive cycles");

endmodule

bind tc_wrapper tc_wrapper_checker i_checker (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .fetch_enable_i ( fetch_enable_i ),
  .instr_req_o    ( instr_req_o    ),
  .instr_gnt_i    ( instr_gnt_i    ),
  .instr_addr_o   ( instr_addr_o   ),
  .trace_valid_o  ( trace_valid_o  )
);

`default_nettype wire
